/* sim/kara_stimulus.hex */
// Per test: id, operand a, operand b, product bits 817:400, product bits 399:0
// Hex words with leading zeros dropped, all values are GF(2) polynomials
00 // zero times dense
0
19E3779B97F4A7C15F39CC3A5E8D26B7F0B4E19A2D58C36F07E2B9D61A4C8E47A0F5B3986C2D9F1E53F1A7B8C04B6E95D2A71
0
0
01 // all ones times one
1FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
1
1FF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
02 // top bit times top bit
1000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000
1000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000
100000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000
0
03 // dense times one
19E3779B97F4A7C15F39CC3A5E8D26B7F0B4E19A2D58C36F07E2B9D61A4C8E47A0F5B3986C2D9F1E53F1A7B8C04B6E95D2A71
1
1
9E3779B97F4A7C15F39CC3A5E8D26B7F0B4E19A2D58C36F07E2B9D61A4C8E47A0F5B3986C2D9F1E53F1A7B8C04B6E95D2A71
04 // all ones squared
1FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
1FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
155555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
5555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
05 // dense squared
19E3779B97F4A7C15F39CC3A5E8D26B7F0B4E19A2D58C36F07E2B9D61A4C8E47A0F5B3986C2D9F1E53F1A7B8C04B6E95D2A71
19E3779B97F4A7C15F39CC3A5E8D26B7F0B4E19A2D58C36F07E2B9D61A4C8E47A0F5B3986C2D9F1E53F1A7B8C04B6E95D2A71
14154051515414541155510441550011155054150500544115440510414451555004510540141440451114050051455001554
0445415114014410504054101544005511450541401450045141550154110555014415454050001045145441115104441501
06 // full width dense squared
1019E3779B97F4A7C15F39CC3A5E8D26B7F0B4E19A2D58C36F07E2B9D61A4C8E47A0F5B3986C2D9F1E53F1A7B8C04B6E95D2A71
1019E3779B97F4A7C15F39CC3A5E8D26B7F0B4E19A2D58C36F07E2B9D61A4C8E47A0F5B3986C2D9F1E53F1A7B8C04B6E95D2A71
100014154051515414541155510441550011155054150500544115440510414451555004510540141440451114050051455001554
0445415114014410504054101544005511450541401450045141550154110555014415454050001045145441115104441501
07 // dense times dense shifted by four
19E3779B97F4A7C15F39CC3A5E8D26B7F0B4E19A2D58C36F07E2B9D61A4C8E47A0F5B3986C2D9F1E53F1A7B8C04B6E95D2A71
19E3779B97F4A7C15F39CC3A5E8D26B7F0B4E19A2D58C36F07E2B9D61A4C8E47A0F5B3986C2D9F1E53F1A7B8C04B6E95D2A710
141540515154145411555104415500111550541505005441154405104144515550045105401414404511140500514550015540
4454151140144105040541015440055114505414014500451415501541105550144154540500010451454411151044415010

/* project.f */
+incdir+design
design/gf2_poly_pkg.sv
design/kara_ctrl_pkg.sv
design/serial_clmul.sv
design/kara_operand_split.sv
design/kara_recombine.sv
design/kara_mul_top.sv
sim/kara_mul_assert.sv
sim/kara_mul_tb.sv

/* sim/kara_mul_tb.sv */
/*
 * Testbench for the Karatsuba GF(2)[x] multiplier.
 * Reads operand pairs and expected products from sim/kara_stimulus.hex and runs
 * edge, dense, busy, reset and back-to-back cases against the top level.
 */
`timescale 1ns/1ps
`include "kara_cfg.svh"

module kara_mul_tb;

	import gf2_poly_pkg::*;
	import kara_ctrl_pkg::*;

	localparam int REC_N   = 8;
	localparam int REC_W   = 5;
	localparam int LATENCY = `KARA_ITER + 2;
	localparam int TIMEOUT = 4 * LATENCY;

	logic         clk;
	logic         rst;
	logic         start;
	poly_pair_t   operands;
	prod_t        product;
	kara_status_t status;

	// File words, then the unpacked records
	logic [419:0] raw [0:REC_N*REC_W-1];
	int           rec_id [REC_N];
	poly_t        rec_a [REC_N];
	poly_t        rec_b [REC_N];
	prod_t        rec_p [REC_N];

	int errors;
	int tests_run;
	int tests_failed;

	kara_mul_top i_kara_mul_top (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.operands (operands),
		.product  (product),
		.status   (status)
	);

	always #2 clk = ~clk;

	task automatic check_value(input string name, input prod_t expected, input prod_t actual);
		if (actual !== expected) begin
			$display("mismatch %s expected %0h actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("error: %s", msg);
		errors++;
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %s ok", name);
		end else begin
			tests_failed++;
			$display("test %s failed", name);
		end
	endtask

	task automatic load_records();
		int base;
		$readmemh("sim/kara_stimulus.hex", raw);
		for (int i = 0; i < REC_N; i++) begin
			base      = i * REC_W;
			rec_id[i] = int'(raw[base]);
			rec_a[i]  = raw[base + 1][`KARA_W-1:0];
			rec_b[i]  = raw[base + 2][`KARA_W-1:0];
			// Product is stored split at bit 400
			rec_p[i]  = {raw[base + 3][2*`KARA_W-401:0], raw[base + 4][399:0]};
			if (rec_id[i] != i)
				report_error($sformatf("stimulus record %0d carries id %0d", i, rec_id[i]));
		end
	endtask

	// Returns one falling edge after the start edge
	task automatic pulse_start(input int idx);
		@(negedge clk);
		operands.a = rec_a[idx];
		operands.b = rec_b[idx];
		start      = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	// Cycles are counted from the start edge to the edge that sees done
	task automatic wait_done(input string name, output int cycles);
		bit busy_low;
		cycles   = 1;
		busy_low = 1'b0;
		while (!status.done && cycles < TIMEOUT) begin
			if (!status.busy)
				busy_low = 1'b1;
			@(negedge clk);
			cycles++;
		end
		if (busy_low)
			report_error($sformatf("%s: busy went low before done", name));
		if (!status.done)
			report_error($sformatf("timeout: %s saw no done within %0d cycles", name, TIMEOUT));
	endtask

	task automatic watch_no_done(input string name, input int window);
		int seen;
		seen = 0;
		for (int c = 0; c < window; c++) begin
			@(negedge clk);
			if (status.done)
				seen++;
		end
		if (seen != 0)
			report_error($sformatf("%s: %0d unexpected done pulses", name, seen));
	endtask

	task automatic start_and_check(input string name, input int idx);
		int cycles;
		pulse_start(idx);
		wait_done(name, cycles);
		check_value(name, rec_p[idx], product);
		check_value({name, "_latency"}, prod_t'(LATENCY), prod_t'(cycles));
	endtask

	initial begin
		int gap;
		int err_before;
		string name;
		clk          = 1'b0;
		rst          = 1'b1;
		start        = 1'b0;
		operands     = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		void'($urandom(65612));
		load_records();

		repeat (16) @(negedge clk);
		rst        = 1'b0;
		err_before = errors;
		check_value("reset_product", '0, product);
		if (status.busy || status.done)
			report_error("busy or done high after reset");
		end_test("reset", err_before);

		// Every record in file order with random idle gaps
		for (int i = 0; i < REC_N; i++) begin
			gap = $urandom_range(6, 0);
			repeat (gap) @(negedge clk);
			name       = $sformatf("rec_%0d", rec_id[i]);
			err_before = errors;
			start_and_check(name, i);
			end_test(name, err_before);
		end

		// Second start with other operands lands mid job
		err_before = errors;
		pulse_start(6);
		repeat ($urandom_range(40, 2)) @(negedge clk);
		operands.a = rec_a[5];
		operands.b = rec_b[5];
		start      = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_done("busy_start", gap);
		check_value("busy_start", rec_p[6], product);
		watch_no_done("busy_start", LATENCY + 8);
		end_test("busy_start", err_before);

		err_before = errors;
		pulse_start(3);
		repeat ($urandom_range(150, 20)) @(negedge clk);
		rst = 1'b1;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		if (status.busy || status.done)
			report_error("reset_mid: busy or done still high after reset");
		check_value("reset_mid_clear", '0, product);
		watch_no_done("reset_mid", LATENCY + 8);
		start_and_check("reset_mid_restart", 4);
		end_test("reset_mid", err_before);

		// Each start on the cycle after the previous done
		err_before = errors;
		for (int k = 5; k < REC_N; k++)
			start_and_check($sformatf("b2b_%0d", k), k);
		start_and_check("b2b_1", 1);
		end_test("back_to_back", err_before);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* sim/kara_mul_assert.sv */
/*
 * Concurrent checks on start, busy, done and the operand capture.
 * Bound into every kara_mul_top instance by the bind at the end of this file.
 */
`timescale 1ns/1ps
`include "kara_cfg.svh"

module kara_mul_assert (
	input logic                        clk,
	input logic                        rst,
	input logic                        start,
	input logic                        go,
	input gf2_poly_pkg::half_ops_t     half_ops,
	input kara_ctrl_pkg::kara_status_t status
);

	// From the edge that takes start to the edge that samples done
	localparam int LATENCY = `KARA_ITER + 2;

	logic accepted;

	assign accepted = start && !status.busy;

	a_done_one_cycle: assert property (@(posedge clk) disable iff (rst)
		status.done |=> !status.done)
		else $error("done stayed high for more than one cycle");

	// Quiet until exactly LATENCY edges after the accepted start
	a_done_latency: assert property (@(posedge clk) disable iff (rst)
		accepted |-> ##1 !status.done [*LATENCY-1] ##1 status.done)
		else $error("done did not follow the accepted start by %0d cycles", LATENCY);

	a_idle_after_reset: assert property (@(posedge clk)
		rst |=> !status.busy)
		else $error("busy high right after reset");

	// An ignored start neither restarts the serial units nor touches their operands
	a_busy_start_ignored: assert property (@(posedge clk) disable iff (rst)
		(start && status.busy) |=> (!go && $stable(half_ops)))
		else $error("start during busy restarted the serial units");

endmodule

bind kara_mul_top kara_mul_assert i_kara_mul_assert (
	.clk      (clk),
	.rst      (rst),
	.start    (start),
	.go       (go),
	.half_ops (half_ops),
	.status   (status)
);

/* design/kara_mul_top.sv */
/*
 * Top level of the 409-bit two-way Karatsuba GF(2)[x] multiplier.
 * Pulse start with operands, product is valid from the done pulse on.
 */
`timescale 1ns/1ps

module kara_mul_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       start,
	input  gf2_poly_pkg::poly_pair_t    operands,
	output gf2_poly_pkg::prod_t         product,
	output kara_ctrl_pkg::kara_status_t status
);

	import gf2_poly_pkg::*;
	import kara_ctrl_pkg::*;

	half_ops_t  half_ops;
	logic       go;
	logic       busy;
	logic       res_done;

	hi_prod_t   hh_prod;
	lo_prod_t   ll_prod;
	hi_prod_t   mm_prod;
	logic       hh_done;
	logic       ll_done;
	logic       mm_done;
	part_done_t part_done;

	kara_operand_split i_split (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.operands    (operands),
		.result_done (res_done),
		.half_ops    (half_ops),
		.go          (go),
		.busy        (busy)
	);

	// High by high
	serial_clmul #(.operand_t(hi_half_t), .product_t(hi_prod_t)) i_mul_hh (
		.clk (clk), .rst (rst), .go (go),
		.x (half_ops.hi_a), .y (half_ops.hi_b), .p (hh_prod), .done (hh_done)
	);

	// Low by low
	serial_clmul #(.operand_t(lo_half_t), .product_t(lo_prod_t)) i_mul_ll (
		.clk (clk), .rst (rst), .go (go),
		.x (half_ops.lo_a), .y (half_ops.lo_b), .p (ll_prod), .done (ll_done)
	);

	// Sum by sum
	serial_clmul #(.operand_t(hi_half_t), .product_t(hi_prod_t)) i_mul_mm (
		.clk (clk), .rst (rst), .go (go),
		.x (half_ops.sum_a), .y (half_ops.sum_b), .p (mm_prod), .done (mm_done)
	);

	assign part_done = '{hh: hh_done, ll: ll_done, mm: mm_done};

	kara_recombine i_recombine (
		.clk       (clk),
		.rst       (rst),
		.go        (go),
		.hh        (hh_prod),
		.ll        (ll_prod),
		.mm        (mm_prod),
		.part_done (part_done),
		.product   (product),
		.done      (res_done)
	);

	assign status = '{busy: busy, done: res_done};

endmodule

/* design/kara_recombine.sv */
/*
 * Karatsuba recombination of the three partial products.
 * Collects the serial results after go, then registers the product and pulses done.
 */
`timescale 1ns/1ps
`include "kara_cfg.svh"

module kara_recombine (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     go,
	input  gf2_poly_pkg::hi_prod_t   hh,
	input  gf2_poly_pkg::lo_prod_t   ll,
	input  gf2_poly_pkg::hi_prod_t   mm,
	input  kara_ctrl_pkg::part_done_t part_done,
	output gf2_poly_pkg::prod_t      product,
	output logic                     done
);

	import gf2_poly_pkg::*;
	import kara_ctrl_pkg::*;

	// Parts seen since the last go
	part_done_t got;
	logic       all_in;

	hi_prod_t hh_q;
	lo_prod_t ll_q;
	hi_prod_t mm_q;

	// A part arriving this cycle is used directly
	hi_prod_t hh_sel;
	lo_prod_t ll_sel;
	hi_prod_t mm_sel;
	hi_prod_t mid;
	prod_t    next_prod;

	always_comb begin
		hh_sel = part_done.hh ? hh : hh_q;
		ll_sel = part_done.ll ? ll : ll_q;
		mm_sel = part_done.mm ? mm : mm_q;
		all_in = (got.hh | part_done.hh) & (got.ll | part_done.ll) & (got.mm | part_done.mm);

		// Subtraction is XOR as well
		mid = mm_sel ^ hh_sel ^ hi_prod_t'(ll_sel);
		next_prod = (prod_t'(hh_sel) << (2 * `KARA_SPLIT))
			^ (prod_t'(mid) << `KARA_SPLIT)
			^ prod_t'(ll_sel);
	end

	always_ff @(posedge clk) begin
		if (part_done.hh)
			hh_q <= hh;
		if (part_done.ll)
			ll_q <= ll;
		if (part_done.mm)
			mm_q <= mm;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			got     <= '0;
			done    <= 1'b0;
			product <= '0;
		end else begin
			done <= 1'b0;
			if (go) begin
				got <= '0;
			end else if (all_in) begin
				got     <= '0;
				product <= next_prod;
				done    <= 1'b1;
			end else begin
				got <= part_done_t'(got | part_done);
			end
		end
	end

endmodule

/* design/kara_operand_split.sv */
/*
 * Operand capture for the Karatsuba multiplier.
 * Registers halves and half sums on an accepted start and starts the serial units.
 */
`timescale 1ns/1ps
`include "kara_cfg.svh"

module kara_operand_split (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  gf2_poly_pkg::poly_pair_t operands,
	input  logic                    result_done,
	output gf2_poly_pkg::half_ops_t  half_ops,
	output logic                    go,
	output logic                    busy
);

	import gf2_poly_pkg::*;

	half_ops_t next_ops;
	logic      accept;

	// Starts arriving while a job runs are dropped
	assign accept = start && !busy;

	always_comb begin
		next_ops.hi_a = operands.a[`KARA_W-1:`KARA_SPLIT];
		next_ops.lo_a = operands.a[`KARA_SPLIT-1:0];
		next_ops.hi_b = operands.b[`KARA_W-1:`KARA_SPLIT];
		next_ops.lo_b = operands.b[`KARA_SPLIT-1:0];
		// Addition in GF(2) is XOR, low half zero extended
		next_ops.sum_a = next_ops.hi_a ^ hi_half_t'(next_ops.lo_a);
		next_ops.sum_b = next_ops.hi_b ^ hi_half_t'(next_ops.lo_b);
	end

	// Held until the next accepted start
	always_ff @(posedge clk) begin
		if (accept)
			half_ops <= next_ops;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			go   <= 1'b0;
			busy <= 1'b0;
		end else begin
			go <= accept;
			if (accept)
				busy <= 1'b1;
			else if (result_done)
				busy <= 1'b0;
		end
	end

endmodule

/* design/serial_clmul.sv */
/*
 * Bit-serial shift-and-XOR carry-less multiplier.
 * A go pulse starts a job of KARA_ITER steps, x and y must stay stable until done.
 */
`timescale 1ns/1ps
`include "kara_cfg.svh"

module serial_clmul #(
	parameter type operand_t = logic [7:0],
	parameter type product_t = logic [14:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     go,
	input  operand_t x,
	input  operand_t y,
	output product_t p,
	output logic     done
);

	// x padded to the step count so that unused upper steps read zero
	logic [`KARA_ITER-1:0] x_ext;

	product_t              acc;
	logic [`KARA_CNT_W-1:0] cnt;
	logic                  run;

	// Step inputs, restarted from zero on go
	product_t              base;
	logic [`KARA_CNT_W-1:0] idx;
	product_t              term;

	assign x_ext = `KARA_ITER'(x);

	always_comb begin
		base = go ? '0 : acc;
		idx  = go ? '0 : cnt;
		if (x_ext[idx])
			term = product_t'(y) << idx;
		else
			term = '0;
	end

	// The go cycle already handles bit 0
	always_ff @(posedge clk) begin
		if (go || run)
			acc <= base ^ term;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt  <= '0;
			run  <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (go || run) begin
				if (idx == `KARA_CNT_W'(`KARA_ITER - 1)) begin
					cnt  <= '0;
					run  <= 1'b0;
					done <= 1'b1;
				end else begin
					cnt <= idx + 1'b1;
					run <= 1'b1;
				end
			end
		end
	end

	assign p = acc;

endmodule

/* design/kara_ctrl_pkg.sv */
/*
 * Control and status records for the Karatsuba multiplier.
 * Shared by the splitter, the serial units, the recombiner and the top level.
 */
package kara_ctrl_pkg;

	// One done strobe per serial unit
	typedef struct packed {
		logic hh;
		logic ll;
		logic mm;
	} part_done_t;

	// Status seen at the top level
	typedef struct packed {
		logic busy;
		logic done;
	} kara_status_t;

endpackage

/* design/gf2_poly_pkg.sv */
/*
 * Polynomial data types for the Karatsuba GF(2)[x] multiplier.
 * Covers full operands, halves, half sums and the partial products.
 */
`include "kara_cfg.svh"

package gf2_poly_pkg;

	// Full operand
	typedef logic [`KARA_W-1:0] poly_t;

	// Low half of an operand
	typedef logic [`KARA_SPLIT-1:0] lo_half_t;

	// High half, also wide enough for a half sum
	typedef logic [`KARA_HI_W-1:0] hi_half_t;

	// Carry-less products have 2n-1 significant bits
	typedef logic [2*`KARA_SPLIT-2:0] lo_prod_t;
	typedef logic [2*`KARA_HI_W-2:0] hi_prod_t;

	// Result port, one bit wider than the significant product
	typedef logic [2*`KARA_W-1:0] prod_t;

	typedef struct packed {
		poly_t a;
		poly_t b;
	} poly_pair_t;

	typedef struct packed {
		hi_half_t hi_a;
		hi_half_t hi_b;
		lo_half_t lo_a;
		lo_half_t lo_b;
		hi_half_t sum_a;
		hi_half_t sum_b;
	} half_ops_t;

endpackage

/* design/kara_cfg.svh */
/*
 * Width settings for the two-way Karatsuba GF(2) multiplier.
 * Included by the packages and modules that size or slice operands.
 */
`ifndef KARA_CFG_SVH
`define KARA_CFG_SVH

// Full operand width
`define KARA_W 409

// Low half width, also the shift of the middle term
`define KARA_SPLIT 204

// High half and half-sum width
`define KARA_HI_W 205

// Serial steps per job, set by the widest serial operand
`define KARA_ITER 205

// Bit counter width, must hold KARA_ITER - 1
`define KARA_CNT_W 8

`endif
